//--- logic/tile_route_pkg.sv
`default_nettype none

package tile_route_pkg;

	localparam int NUM_SIDES = 4;
	localparam int NUM_TRACKS = 4;
	localparam int NUM_OUT_SIDES = 3; // The east side of the corner tile has no outputs.

	// Source selects for an output track on side s.
	// Codes 0 to 2 walk the other three sides in ascending order and take the same track.
	localparam logic [1:0] SRC_OTHER_0 = 2'd0;
	localparam logic [1:0] SRC_OTHER_1 = 2'd1;
	localparam logic [1:0] SRC_OTHER_2 = 2'd2;
	localparam logic [1:0] SRC_PE = 2'd3; // Registered logic-block result.

	localparam logic [1:0] LB_AND = 2'd0;
	localparam logic [1:0] LB_OR = 2'd1;
	localparam logic [1:0] LB_XOR = 2'd2;
	localparam logic [1:0] LB_NAND = 2'd3;

endpackage

`default_nettype wire

//--- logic/tile_cfg_pkg.sv
`default_nettype none

package tile_cfg_pkg;

	// Section numbers, compared against cfg_addr[31:16].
	localparam logic [15:0] SEC_SB = 16'd7;
	localparam logic [15:0] SEC_CB0 = 16'd6;
	localparam logic [15:0] SEC_CB1 = 16'd5;
	localparam logic [15:0] SEC_LB = 16'd4;

	// Byte offsets of the AXI4-Lite register map.
	localparam logic [31:0] REG_CFG_ADDR = 32'h0;
	localparam logic [31:0] REG_CFG_DATA = 32'h4;
	localparam logic [31:0] REG_READBACK = 32'h8;

	// One configuration word, seen either by the switch box or by a single-select leaf.
	typedef union packed {
		struct packed {
			logic [7:0] unused;
			// Indexed src[side][track]; side 0, track 0 sits in bits 1:0.
			logic [tile_route_pkg::NUM_OUT_SIDES-1:0][tile_route_pkg::NUM_TRACKS-1:0][1:0] src;
		} sb;
		struct packed {
			logic [28:0] unused;
			logic [2:0] sel; // The logic block uses only the low two bits.
		} low;
	} cfg_word_u;

endpackage

`default_nettype wire

//--- logic/cfg_axil_slave.sv
`timescale 1ns/1ns
`default_nettype none

module cfg_axil_slave (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic        bvalid,
	input  logic        bready,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic        rvalid,
	input  logic        rready,
	input  logic [31:0] cfg_readback,
	output logic [31:0] cfg_addr,
	output logic [31:0] cfg_data,
	output logic        cfg_strobe
);

	logic        wr_accept;
	logic        wr_addr_reg;
	logic        wr_data_reg;
	logic        rd_accept;
	logic [31:0] rd_word;

	// Address and data are taken together, and only with no response outstanding.
	assign wr_accept = awvalid && wvalid && !bvalid;
	assign awready = wr_accept;
	assign wready = wr_accept;

	assign wr_addr_reg = wr_accept && (awaddr == tile_cfg_pkg::REG_CFG_ADDR);
	assign wr_data_reg = wr_accept && (awaddr == tile_cfg_pkg::REG_CFG_DATA);

	assign arready = !rvalid; // One read in flight at a time.
	assign rd_accept = arvalid && arready;

	always_comb begin
		case (araddr)
			tile_cfg_pkg::REG_CFG_ADDR: rd_word = cfg_addr;
			tile_cfg_pkg::REG_READBACK: rd_word = cfg_readback; // Word of the addressed section.
			default: rd_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bvalid <= 1'b0;
			cfg_strobe <= 1'b0;
			cfg_addr <= '0;
		end else begin
			cfg_strobe <= wr_data_reg; // High for the single cycle after the data write.
			if (wr_accept) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (wr_addr_reg) begin
				cfg_addr <= wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_data_reg) begin
			cfg_data <= wdata; // Only consumed while cfg_strobe is high.
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else if (rd_accept) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept) begin
			rdata <= rd_word;
		end
	end

endmodule

`default_nettype wire

//--- logic/connect_box.sv
`timescale 1ns/1ns
`default_nettype none

module connect_box (
	input  logic        clk,
	input  logic        rst,
	input  logic        config_en,
	input  logic [31:0] config_data,
	input  logic [7:0]  tracks,
	output logic        block_out,
	output logic [31:0] cfg_word
);

	tile_cfg_pkg::cfg_word_u cfg_in;
	tile_cfg_pkg::cfg_word_u cfg_out;
	logic [2:0] sel_q;

	assign cfg_in = config_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_q <= '0;
		end else if (config_en) begin
			sel_q <= cfg_in.low.sel;
		end
	end

	assign block_out = tracks[sel_q]; // Plain mux, no register on the operand path.

	always_comb begin
		cfg_out = '0;
		cfg_out.low.sel = sel_q;
	end

	assign cfg_word = cfg_out;

endmodule

`default_nettype wire

//--- logic/switch_box.sv
`timescale 1ns/1ns
`default_nettype none

module switch_box (
	input  logic clk,
	input  logic rst,
	input  logic config_en,
	input  logic [31:0] config_data,
	input  logic [tile_route_pkg::NUM_SIDES*tile_route_pkg::NUM_TRACKS-1:0] in_wires,
	input  logic pe_result,
	output logic [tile_route_pkg::NUM_OUT_SIDES*tile_route_pkg::NUM_TRACKS-1:0] out_wires,
	output logic [31:0] cfg_word
);

	tile_cfg_pkg::cfg_word_u cfg_in;
	tile_cfg_pkg::cfg_word_u cfg_out;
	logic [tile_route_pkg::NUM_OUT_SIDES-1:0][tile_route_pkg::NUM_TRACKS-1:0][1:0] src_q;

	assign cfg_in = config_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			src_q <= '0;
		end else if (config_en) begin
			src_q <= cfg_in.sb.src;
		end
	end

	always_comb begin
		cfg_out = '0;
		cfg_out.sb.src = src_q; // Upper byte reads back as zero.
	end

	assign cfg_word = cfg_out;

	for (genvar s = 0; s < tile_route_pkg::NUM_OUT_SIDES; s++) begin : g_side
		for (genvar t = 0; t < tile_route_pkg::NUM_TRACKS; t++) begin : g_track
			// Code k names the k-th other side, counting up and skipping side s.
			localparam int IDX_A = ((0 < s) ? 0 : 1) * tile_route_pkg::NUM_TRACKS + t;
			localparam int IDX_B = ((1 < s) ? 1 : 2) * tile_route_pkg::NUM_TRACKS + t;
			localparam int IDX_C = ((2 < s) ? 2 : 3) * tile_route_pkg::NUM_TRACKS + t;

			logic route_bit;

			always_comb begin
				case (src_q[s][t])
					tile_route_pkg::SRC_OTHER_0: route_bit = in_wires[IDX_A];
					tile_route_pkg::SRC_OTHER_1: route_bit = in_wires[IDX_B];
					tile_route_pkg::SRC_OTHER_2: route_bit = in_wires[IDX_C];
					tile_route_pkg::SRC_PE: route_bit = pe_result;
				endcase
			end

			assign out_wires[s*tile_route_pkg::NUM_TRACKS+t] = route_bit;
		end
	end

endmodule

`default_nettype wire

//--- logic/logic_block.sv
`timescale 1ns/1ns
`default_nettype none

module logic_block (
	input  logic        clk,
	input  logic        rst,
	input  logic        config_en,
	input  logic [31:0] config_data,
	input  logic        op_0,
	input  logic        op_1,
	output logic        pe_result,
	output logic [31:0] cfg_word
);

	tile_cfg_pkg::cfg_word_u cfg_in;
	tile_cfg_pkg::cfg_word_u cfg_out;
	logic [1:0] func_q;
	logic       func_out;

	assign cfg_in = config_data;

	always_comb begin
		case (func_q)
			tile_route_pkg::LB_AND: func_out = op_0 & op_1;
			tile_route_pkg::LB_OR: func_out = op_0 | op_1;
			tile_route_pkg::LB_XOR: func_out = op_0 ^ op_1;
			tile_route_pkg::LB_NAND: func_out = ~(op_0 & op_1);
		endcase
	end

	// The result register is what keeps the switch-box feedback path acyclic.
	always_ff @(posedge clk) begin
		if (rst) begin
			func_q <= tile_route_pkg::LB_AND;
			pe_result <= 1'b0;
		end else begin
			if (config_en) begin
				func_q <= cfg_in.low.sel[1:0];
			end
			pe_result <= func_out;
		end
	end

	always_comb begin
		cfg_out = '0;
		cfg_out.low.sel = {1'b0, func_q};
	end

	assign cfg_word = cfg_out;

endmodule

`default_nettype wire

//--- logic/pe_tile.sv
`timescale 1ns/1ns
`default_nettype none

module pe_tile (
	input  logic clk,
	input  logic rst,
	input  logic [15:0] tile_id,
	input  logic [31:0] cfg_addr,
	input  logic [31:0] cfg_data,
	input  logic cfg_strobe,
	input  logic [tile_route_pkg::NUM_SIDES*tile_route_pkg::NUM_TRACKS-1:0] in_wires,
	output logic [tile_route_pkg::NUM_OUT_SIDES*tile_route_pkg::NUM_TRACKS-1:0] out_wires,
	output logic [31:0] cfg_readback
);

	logic        tile_hit;
	logic [15:0] section;
	logic        en_sb;
	logic        en_cb0;
	logic        en_cb1;
	logic        en_lb;
	logic        op_0;
	logic        op_1;
	logic        pe_result;
	logic [31:0] word_sb;
	logic [31:0] word_cb0;
	logic [31:0] word_cb1;
	logic [31:0] word_lb;

	assign tile_hit = (cfg_addr[15:0] == tile_id);
	assign section = cfg_addr[31:16];

	assign en_sb = cfg_strobe && tile_hit && (section == tile_cfg_pkg::SEC_SB);
	assign en_cb0 = cfg_strobe && tile_hit && (section == tile_cfg_pkg::SEC_CB0);
	assign en_cb1 = cfg_strobe && tile_hit && (section == tile_cfg_pkg::SEC_CB1);
	assign en_lb = cfg_strobe && tile_hit && (section == tile_cfg_pkg::SEC_LB);

	always_comb begin
		cfg_readback = '0;
		if (tile_hit) begin
			case (section)
				tile_cfg_pkg::SEC_SB: cfg_readback = word_sb;
				tile_cfg_pkg::SEC_CB0: cfg_readback = word_cb0;
				tile_cfg_pkg::SEC_CB1: cfg_readback = word_cb1;
				tile_cfg_pkg::SEC_LB: cfg_readback = word_lb;
				default: cfg_readback = '0;
			endcase
		end
	end

	switch_box sb (
		.clk         (clk),
		.rst         (rst),
		.config_en   (en_sb),
		.config_data (cfg_data),
		.in_wires    (in_wires),
		.pe_result   (pe_result),
		.out_wires   (out_wires),
		.cfg_word    (word_sb)
	);

	// Tracks 0 to 3 come in on the side, tracks 4 to 7 are the switch box outputs on it.
	connect_box cb0 (
		.clk         (clk),
		.rst         (rst),
		.config_en   (en_cb0),
		.config_data (cfg_data),
		.tracks      ({out_wires[3:0], in_wires[3:0]}),
		.block_out   (op_0),
		.cfg_word    (word_cb0)
	);

	connect_box cb1 (
		.clk         (clk),
		.rst         (rst),
		.config_en   (en_cb1),
		.config_data (cfg_data),
		.tracks      ({out_wires[7:4], in_wires[7:4]}),
		.block_out   (op_1),
		.cfg_word    (word_cb1)
	);

	logic_block lb (
		.clk         (clk),
		.rst         (rst),
		.config_en   (en_lb),
		.config_data (cfg_data),
		.op_0        (op_0),
		.op_1        (op_1),
		.pe_result   (pe_result),
		.cfg_word    (word_lb)
	);

endmodule

`default_nettype wire

//--- logic/cgra_tile_top.sv
`timescale 1ns/1ns
`default_nettype none

module cgra_tile_top (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic        bvalid,
	input  logic        bready,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic        rvalid,
	input  logic        rready,
	input  logic [15:0] tile_id,
	input  logic [15:0] in_wires,
	output logic [11:0] out_wires
);

	logic [31:0] cfg_addr;
	logic [31:0] cfg_data;
	logic        cfg_strobe;
	logic [31:0] cfg_readback;

	cfg_axil_slave u_cfg_axil_slave (
		.clk          (clk),
		.rst          (rst),
		.awaddr       (awaddr),
		.awvalid      (awvalid),
		.awready      (awready),
		.wdata        (wdata),
		.wvalid       (wvalid),
		.wready       (wready),
		.bvalid       (bvalid),
		.bready       (bready),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rvalid       (rvalid),
		.rready       (rready),
		.cfg_readback (cfg_readback),
		.cfg_addr     (cfg_addr),
		.cfg_data     (cfg_data),
		.cfg_strobe   (cfg_strobe)
	);

	pe_tile u_pe_tile (
		.clk          (clk),
		.rst          (rst),
		.tile_id      (tile_id),
		.cfg_addr     (cfg_addr),
		.cfg_data     (cfg_data),
		.cfg_strobe   (cfg_strobe),
		.in_wires     (in_wires),
		.out_wires    (out_wires),
		.cfg_readback (cfg_readback)
	);

endmodule

`default_nettype wire

//--- verification/tile_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tile_clock_gen (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period.
	end

endmodule

`default_nettype wire

//--- verification/tile_properties.sv
`timescale 1ns/1ns
`default_nettype none

module tile_properties (
	input logic clk,
	input logic rst,
	input logic awvalid,
	input logic awready,
	input logic bvalid,
	input logic bready,
	input logic cfg_strobe
);

	aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid)
		else $error("awvalid dropped before the write address was accepted");

	b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid)
		else $error("bvalid dropped before bready");

	strobe_single: assert property (@(posedge clk) disable iff (rst)
		cfg_strobe |=> !cfg_strobe)
		else $error("cfg_strobe was high two cycles in a row");

endmodule

`default_nettype wire

//--- verification/tile_tb.sv
`timescale 1ns/1ns
`default_nettype none

module tile_tb;

	localparam int CYCLE_LIMIT = 4000; // The tests take roughly 400 cycles.

	logic        clk;
	logic        rst;
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic        bvalid;
	logic        bready;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic        rvalid;
	logic        rready;
	logic [15:0] tile_id;
	logic [15:0] in_wires;
	logic [11:0] out_wires;

	// Model of the tile's configuration and of the result register.
	logic [31:0] cfg_addr_m;
	logic [31:0] sb_m;
	logic [31:0] cb0_m;
	logic [31:0] cb1_m;
	logic [31:0] lb_m;
	logic        pe_m;
	logic        pe_next;
	logic [31:0] lfsr;
	logic [31:0] last_read;
	logic [31:0] word;
	int          cycles = 0;
	logic [15:0] sections [4] = '{tile_cfg_pkg::SEC_SB, tile_cfg_pkg::SEC_CB0,
		tile_cfg_pkg::SEC_CB1, tile_cfg_pkg::SEC_LB};

	tile_clock_gen u_tile_clock_gen (.clk(clk));

	cgra_tile_top u_cgra_tile_top (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rready(rready),
		.tile_id(tile_id), .in_wires(in_wires), .out_wires(out_wires)
	);

	bind cfg_axil_slave tile_properties u_tile_properties (
		.clk(clk), .rst(rst), .awvalid(awvalid), .awready(awready),
		.bvalid(bvalid), .bready(bready), .cfg_strobe(cfg_strobe)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
	endfunction

	task automatic draw(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// Output track t of side s takes track t of the code-th other side, or the result.
	function automatic logic [11:0] route_model(input logic [31:0] sb, input logic [15:0] in_w,
		input logic pe);
		logic [11:0] route;
		logic [1:0]  code;
		int          other;
		for (int s = 0; s < 3; s++) begin
			for (int t = 0; t < 4; t++) begin
				code = sb[(s * 4 + t) * 2 +: 2];
				other = (int'(code) < s) ? int'(code) : int'(code) + 1;
				if (code == 2'd3) begin
					route[s * 4 + t] = pe;
				end else begin
					route[s * 4 + t] = in_w[other * 4 + t];
				end
			end
		end
		return route;
	endfunction

	function automatic logic operand_model(input int k, input logic [2:0] sel,
		input logic [15:0] in_w, input logic [11:0] route);
		if (sel[2]) begin
			return route[k * 4 + int'(sel[1:0])];
		end
		return in_w[k * 4 + int'(sel[1:0])];
	endfunction

	function automatic logic function_model(input logic [1:0] f, input logic a, input logic b);
		case (f)
			tile_route_pkg::LB_AND: return a & b;
			tile_route_pkg::LB_OR: return a | b;
			tile_route_pkg::LB_XOR: return a ^ b;
			default: return ~(a & b);
		endcase
	endfunction

	function automatic logic [31:0] readback_model();
		if (cfg_addr_m[15:0] != tile_id) begin
			return '0;
		end
		case (cfg_addr_m[31:16])
			tile_cfg_pkg::SEC_SB: return sb_m;
			tile_cfg_pkg::SEC_CB0: return cb0_m;
			tile_cfg_pkg::SEC_CB1: return cb1_m;
			tile_cfg_pkg::SEC_LB: return lb_m;
			default: return '0;
		endcase
	endfunction

	task automatic store_model(input logic [31:0] data);
		if (cfg_addr_m[15:0] == tile_id) begin
			case (cfg_addr_m[31:16])
				tile_cfg_pkg::SEC_SB: sb_m = data & 32'h00ff_ffff;
				tile_cfg_pkg::SEC_CB0: cb0_m = data & 32'h7;
				tile_cfg_pkg::SEC_CB1: cb1_m = data & 32'h7;
				tile_cfg_pkg::SEC_LB: lb_m = data & 32'h3;
				default: ;
			endcase
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "Run stopped at the first mismatch.");
		end
	endtask

	task automatic send_write(input logic [31:0] addr, input logic [31:0] data);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		@(posedge clk);
		while (!(awready && wready)) @(posedge clk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		if (addr == tile_cfg_pkg::REG_CFG_ADDR) begin
			cfg_addr_m = data;
		end
		@(posedge clk); // The strobe loads the section on this edge.
		if (addr == tile_cfg_pkg::REG_CFG_DATA) begin
			store_model(data);
		end
	endtask

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data);
		send_write(addr, data);
		while (!(bvalid && bready)) @(posedge clk);
	endtask

	task automatic axi_read(input logic [31:0] addr);
		araddr <= addr;
		arvalid <= 1'b1;
		@(posedge clk);
		while (!arready) @(posedge clk);
		arvalid <= 1'b0;
		@(posedge clk);
		while (!(rvalid && rready)) @(posedge clk);
		last_read = rdata;
	endtask

	task automatic configure(input logic [15:0] sec, input logic [15:0] id,
		input logic [31:0] data);
		axi_write(tile_cfg_pkg::REG_CFG_ADDR, {sec, id});
		axi_write(tile_cfg_pkg::REG_CFG_DATA, data);
	endtask

	task automatic check_readback(input logic [15:0] sec, input logic [15:0] id);
		axi_write(tile_cfg_pkg::REG_CFG_ADDR, {sec, id});
		axi_read(tile_cfg_pkg::REG_READBACK);
		check_value("rdata", last_read, readback_model());
	endtask

	task automatic new_inputs();
		logic [31:0] v;
		draw(16, v);
		in_wires <= v[15:0];
	endtask

	always @(negedge clk) begin : compare
		logic [11:0] exp_out;
		if (rst) begin
			pe_m = 1'b0;
			pe_next = 1'b0;
		end else begin
			pe_m = pe_next; // Result registered on the edge just passed.
			exp_out = route_model(sb_m, in_wires, pe_m);
			check_value("out_wires", 32'(out_wires), 32'(exp_out));
			pe_next = function_model(lb_m[1:0], operand_model(0, cb0_m[2:0], in_wires, exp_out),
				operand_model(1, cb1_m[2:0], in_wires, exp_out));
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$fatal(1, "Run stopped by the cycle limit.");
		end
	end

	initial begin
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		tile_id = 16'h0203;
		in_wires = '0;
		cfg_addr_m = '0;
		sb_m = '0;
		cb0_m = '0;
		cb1_m = '0;
		lb_m = '0;
		lfsr = 32'h7f0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		new_inputs();
		for (int i = 0; i < 4; i++) begin
			check_readback(sections[i], tile_id);
		end
		axi_read(tile_cfg_pkg::REG_CFG_ADDR);
		check_value("rdata", last_read, cfg_addr_m);
		for (int i = 0; i < 8; i++) begin
			draw(32, word);
			configure(sections[i % 4], tile_id, word);
			check_readback(sections[i % 4], tile_id);
			new_inputs();
		end
		for (int i = 0; i < 4; i++) begin
			draw(32, word);
			configure(sections[i], tile_id ^ 16'h0100, word);
			check_readback(sections[i], tile_id ^ 16'h0100); // Another tile reads as zero.
			check_readback(sections[i], tile_id);
		end
		for (int i = 0; i < 8; i++) begin
			draw(32, word);
			configure(tile_cfg_pkg::SEC_SB, tile_id, word);
			repeat (3) begin
				new_inputs();
				@(posedge clk);
			end
		end
		for (int i = 0; i < 8; i++) begin
			for (int j = 1; j < 4; j++) begin
				draw(32, word);
				configure(sections[j], tile_id, word);
			end
			draw(32, word);
			configure(tile_cfg_pkg::SEC_SB, tile_id, word | 32'h00c0_0000); // Side 2 track 3.
			repeat (4) begin
				new_inputs();
				@(posedge clk);
			end
		end
		bready <= 1'b0;
		send_write(tile_cfg_pkg::REG_CFG_ADDR, {tile_cfg_pkg::SEC_LB, tile_id});
		draw(32, word);
		fork
			begin
				repeat (6) begin
					@(posedge clk);
					check_value("bvalid", 32'(bvalid), 32'd1);
					check_value("awready", 32'(awready), 32'd0);
					check_value("wready", 32'(wready), 32'd0);
				end
				bready <= 1'b1;
			end
			axi_write(tile_cfg_pkg::REG_CFG_DATA, word);
		join
		axi_read(tile_cfg_pkg::REG_READBACK);
		check_value("rdata", last_read, readback_model());
		repeat (2) @(posedge clk);
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
logic/tile_route_pkg.sv
logic/tile_cfg_pkg.sv
logic/cfg_axil_slave.sv
logic/connect_box.sv
logic/switch_box.sv
logic/logic_block.sv
logic/pe_tile.sv
logic/cgra_tile_top.sv
verification/tile_clock_gen.sv
verification/tile_properties.sv
verification/tile_tb.sv

//--- Makefile
SRCS := $(shell cat vlog.f)

all: run

obj_dir/Vtile_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module tile_tb -f vlog.f

run: obj_dir/Vtile_tb
	./obj_dir/Vtile_tb

clean:
	rm -rf obj_dir

.PHONY: all run clean
